// File: Makefile
TOP := vga_gc_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -o sim
	@out="$$(./obj_dir/sim +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: dv/vga_gc_checker.sv
`timescale 1ns/1ps

module vga_gc_checker
(
	input logic clk,
	input logic arst_n,
	input logic mrd_req,
	input logic mrd_ack,
	input logic mwr_req,
	input logic mwr_ack,
	input logic iowr_req,
	input logic iowr_ack,
	input logic iord_req,
	input logic iord_ack,
	input logic gpu_rd_req,
	input logic gpu_rd_ack,
	input logic gpu_wr_req,
	input logic gpu_wr_ack
);

	int unsigned error_count = 0;

	//////////////////////////////////////////////////
	// Toggle handshake rules
	//////////////////////////////////////////////////

	// Processor and I/O acknowledges copy req one cycle late
	ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
		mrd_ack == $past(mrd_req) && mwr_ack == $past(mwr_req) &&
		iowr_ack == $past(iowr_req) && iord_ack == $past(iord_req))
	else
	begin
		error_count++;
		$error("acknowledge did not copy its request one cycle later");
	end

	// Store starts only on the edge that completes the read
	wr_after_read: assert property (@(posedge clk) disable iff (!arst_n)
		gpu_wr_req != $past(gpu_wr_req) |-> $past(gpu_rd_ack) == $past(gpu_rd_req))
	else
	begin
		error_count++;
		$error("gpu_wr_req toggled while the memory read was still open");
	end

	rd_when_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		gpu_rd_req != $past(gpu_rd_req) |->
		$past(gpu_rd_ack) == $past(gpu_rd_req) && $past(gpu_wr_ack) == $past(gpu_wr_req))
	else
	begin
		error_count++;
		$error("gpu_rd_req toggled while a memory request was pending");
	end

	reset_clears_req: assert property (@(posedge clk) !arst_n |->
		!gpu_rd_req && !gpu_wr_req && !mrd_ack && !mwr_ack && !iowr_ack && !iord_ack)
	else
	begin
		error_count++;
		$error("toggle outputs not cleared by reset");
	end

endmodule

bind vga_gc_top vga_gc_checker u_checker (.*);

// File: dv/vga_gc_tb.sv
`timescale 1ns/1ps

module vga_gc_tb
	import vga_gc_pkg::*;
();

	localparam logic [7:0] SEGMENT = 8'h0A;
	localparam int CLK_PERIOD = 20;
	localparam int READS_PER_MODE = 8;
	localparam int WRITES_PER_MODE = 6;
	// Two read modes, four write modes and two filtered accesses
	localparam int NUM_ACCESSES = 2 * READS_PER_MODE + 4 * WRITES_PER_MODE + 2;
	localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 200 + 1000;

	logic clk = 1'b0;
	logic arst_n;
	logic [23:0] a;
	logic [7:0] din;
	logic [7:0] dout;
	logic mrd_req;
	logic mrd_ack;
	logic mwr_req;
	logic mwr_ack;
	io_port_t port;
	logic [15:0] iodin;
	logic [15:0] iodout;
	logic iowr_req;
	logic iowr_ack;
	logic iord_req;
	logic iord_ack;
	logic [23:0] gpu_addr;
	plane_word_t gpu_dout;
	plane_word_t gpu_din;
	logic gpu_rd_ack;
	logic gpu_rd_req;
	logic gpu_wr_ack;
	logic gpu_wr_req;
	logic ready;

	integer seed;
	plane_word_t mem [64];
	plane_word_t latch_model;

	// Shadow copy of the control fields
	logic [3:0] sr;
	logic [3:0] esr;
	logic [3:0] cmp;
	logic [3:0] dc;
	logic [3:0] pen;
	logic [2:0] rot;
	logic [1:0] lop;
	logic [1:0] rplane;
	logic [1:0] wmode;
	logic rmode;
	logic [7:0] bmask;

	vga_gc_top #(
		.VRAM_SEGMENT(SEGMENT)
	) dut (
		.clk(clk),
		.arst_n(arst_n),
		.a(a),
		.din(din),
		.dout(dout),
		.mrd_req(mrd_req),
		.mrd_ack(mrd_ack),
		.mwr_req(mwr_req),
		.mwr_ack(mwr_ack),
		.port(port),
		.iodin(iodin),
		.iodout(iodout),
		.iowr_req(iowr_req),
		.iowr_ack(iowr_ack),
		.iord_req(iord_req),
		.iord_ack(iord_ack),
		.gpu_addr(gpu_addr),
		.gpu_dout(gpu_dout),
		.gpu_din(gpu_din),
		.gpu_rd_ack(gpu_rd_ack),
		.gpu_rd_req(gpu_rd_req),
		.gpu_wr_ack(gpu_wr_ack),
		.gpu_wr_req(gpu_wr_req),
		.ready(ready)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic logic [7:0] rotate_right(input logic [7:0] value, input logic [2:0] amount);
		rotate_right = value;
		for (int i = 0; i < amount; i++)
			rotate_right = {rotate_right[0], rotate_right[7:1]};
	endfunction

	function automatic plane_word_t expected_store(input logic [7:0] data,
		input plane_word_t latch_word, input plane_word_t mem_word);
		logic [7:0] rotated;
		logic [7:0] l;
		logic [7:0] opnd;
		logic [7:0] mask;
		logic [7:0] r;
		rotated = rotate_right(data, rot);
		for (int p = 0; p < 4; p++)
		begin
			l = latch_word[p*8 +: 8];
			mask = bmask;
			case (wmode)
				2'd0: opnd = esr[p] ? {8{sr[p]}} : rotated;
				2'd1: opnd = l;
				2'd2: opnd = {8{data[p]}};
				default:
				begin
					opnd = {8{sr[p]}};
					mask = rotated & bmask;
				end
			endcase
			case (lop)
				2'd0: r = opnd;
				2'd1: r = opnd & l;
				2'd2: r = opnd | l;
				default: r = opnd ^ l;
			endcase
			// Mode 1 puts the latch back untouched
			if (wmode == 2'd1)
				r = l;
			else
				r = (r & mask) | (l & ~mask);
			expected_store[p*8 +: 8] = pen[p] ? r : mem_word[p*8 +: 8];
		end
	endfunction

	function automatic logic [7:0] expected_read(input plane_word_t mem_word);
		expected_read = mem_word[rplane*8 +: 8];
		if (rmode)
		begin
			for (int i = 0; i < 8; i++)
			begin
				expected_read[i] = 1'b1;
				for (int p = 0; p < 4; p++)
					if (dc[p] && mem_word[p*8 + i] != cmp[p])
						expected_read[i] = 1'b0;
			end
		end
	endfunction

	//////////////////////////////////////////////////
	// Checks and bus tasks
	//////////////////////////////////////////////////

	task automatic compare_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic io_write(input io_port_t p, input logic [7:0] value);
		@(negedge clk);
		port = p;
		iodin = {8'h00, value};
		iowr_req = ~iowr_req;
		@(negedge clk);
	endtask

	task automatic io_read(input io_port_t p, output logic [7:0] value);
		@(negedge clk);
		port = p;
		iord_req = ~iord_req;
		@(negedge clk);
		value = iodout[7:0];
	endtask

	task automatic write_reg(input logic is_seq, input logic [4:0] index, input logic [7:0] value);
		io_write(is_seq ? PORT_SEQ_INDEX : PORT_GC_INDEX, {3'b000, index});
		io_write(is_seq ? PORT_SEQ_DATA : PORT_GC_DATA, value);
	endtask

	task automatic round_trip(input string name, input logic is_seq, input logic [4:0] index,
		input logic [7:0] field_mask);
		logic [31:0] r;
		logic [7:0] value;
		r = $random(seed);
		write_reg(is_seq, index, r[7:0]);
		io_read(is_seq ? PORT_SEQ_INDEX : PORT_GC_INDEX, value);
		compare_word({name, " index"}, {27'h0, index}, {24'h0, value});
		io_read(is_seq ? PORT_SEQ_DATA : PORT_GC_DATA, value);
		compare_word(name, {24'h0, r[7:0] & field_mask}, {24'h0, value});
	endtask

	task automatic randomize_regs();
		logic [31:0] r;
		logic [31:0] s;
		r = $random(seed);
		s = $random(seed);
		sr = r[3:0];
		esr = r[7:4];
		cmp = r[11:8];
		dc = r[15:12];
		pen = r[19:16];
		rot = r[22:20];
		lop = r[24:23];
		rplane = r[26:25];
		wmode = r[28:27];
		rmode = r[29];
		bmask = s[7:0];
	endtask

	task automatic load_regs();
		write_reg(1'b1, SEQ_MAP_MASK, {4'h0, pen});
		write_reg(1'b1, SEQ_MEM_MODE, 8'h00);
		write_reg(1'b0, GC_SET_RESET, {4'h0, sr});
		write_reg(1'b0, GC_ENABLE_SR, {4'h0, esr});
		write_reg(1'b0, GC_COLOR_CMP, {4'h0, cmp});
		write_reg(1'b0, GC_ROTATE, {3'b000, lop, rot});
		write_reg(1'b0, GC_READ_MAP, {6'b000000, rplane});
		write_reg(1'b0, GC_MODE, {4'h0, rmode, 1'b0, wmode});
		write_reg(1'b0, GC_DONT_CARE, {4'h0, dc});
		write_reg(1'b0, GC_BIT_MASK, bmask);
	endtask

	task automatic wait_ready();
		@(negedge clk);
		while (!ready)
			@(negedge clk);
	endtask

	task automatic do_access(input string name, input logic is_write);
		logic [31:0] r;
		logic [5:0] offset;
		logic [7:0] data;
		plane_word_t old_word;
		r = $random(seed);
		offset = r[5:0];
		data = r[15:8];
		wait_ready();
		old_word = mem[offset];
		a = {SEGMENT, 10'h000, offset};
		din = data;
		if (is_write)
			mwr_req = ~mwr_req;
		else
			mrd_req = ~mrd_req;
		@(negedge clk);
		compare_word({name, " address"}, {8'h00, 24'hA0000 + {16'h0000, offset, 2'b00}},
			{8'h00, gpu_addr});
		wait_ready();
		if (is_write)
			compare_word(name, expected_store(data, latch_model, old_word), mem[offset]);
		else
			compare_word(name, {24'h0, expected_read(old_word)}, {24'h0, dout});
		latch_model = old_word;
	endtask

	task automatic check_filtered(input string name, input logic [23:0] addr);
		logic rd_req_before;
		logic [7:0] dout_before;
		wait_ready();
		rd_req_before = gpu_rd_req;
		dout_before = dout;
		a = addr;
		mrd_req = ~mrd_req;
		mwr_req = ~mwr_req;
		// Acceptance would show on the first edge
		repeat (3) @(negedge clk);
		compare_word({name, " rd_req"}, {31'h0, rd_req_before}, {31'h0, gpu_rd_req});
		compare_word({name, " dout"}, {24'h0, dout_before}, {24'h0, dout});
	endtask

	//////////////////////////////////////////////////
	// Video memory with random latency
	//////////////////////////////////////////////////

	initial
	begin : memory_model
		logic [31:0] r;
		forever
		begin
			@(negedge clk);
			if (gpu_rd_req != gpu_rd_ack || gpu_wr_req != gpu_wr_ack)
			begin
				r = $random(seed);
				repeat (r[1:0]) @(negedge clk);
				if (gpu_rd_req != gpu_rd_ack)
				begin
					gpu_din = mem[gpu_addr[7:2]];
					gpu_rd_ack = gpu_rd_req;
				end
				else
				begin
					mem[gpu_addr[7:2]] = gpu_dout;
					gpu_wr_ack = gpu_wr_req;
				end
			end
		end
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog timeout, the DUT stopped finishing its accesses");
		$display("test failed");
		$fatal(1, "timeout");
	end

	// Stop at the first handshake assertion failure
	initial
	begin
		wait (dut.u_checker.error_count != 0);
		$display("handshake assertion failed in the checker");
		$display("test failed");
		$fatal(1, "checker failure");
	end

	initial
	begin
		seed = 32'hf50d45d6;
		arst_n = 1'b0;
		a = '0;
		din = '0;
		mrd_req = 1'b0;
		mwr_req = 1'b0;
		port = '0;
		iodin = '0;
		iowr_req = 1'b0;
		iord_req = 1'b0;
		gpu_din = '0;
		gpu_rd_ack = 1'b0;
		gpu_wr_ack = 1'b0;
		for (int i = 0; i < 64; i++)
			mem[i] = $random(seed);
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		round_trip("seq map mask", 1'b1, SEQ_MAP_MASK, 8'h0F);
		round_trip("seq memory mode", 1'b1, SEQ_MEM_MODE, 8'h08);
		round_trip("gc set reset", 1'b0, GC_SET_RESET, 8'h0F);
		round_trip("gc enable set reset", 1'b0, GC_ENABLE_SR, 8'h0F);
		round_trip("gc color compare", 1'b0, GC_COLOR_CMP, 8'h0F);
		round_trip("gc rotate", 1'b0, GC_ROTATE, 8'h1F);
		round_trip("gc read map", 1'b0, GC_READ_MAP, 8'h03);
		round_trip("gc mode", 1'b0, GC_MODE, 8'h0B);
		round_trip("gc dont care", 1'b0, GC_DONT_CARE, 8'h0F);
		round_trip("gc bit mask", 1'b0, GC_BIT_MASK, 8'hFF);

		for (int i = 0; i < READS_PER_MODE; i++)
		begin
			randomize_regs();
			rmode = 1'b0;
			load_regs();
			do_access("read mode 0", 1'b0);
		end

		check_filtered("wrong segment", {8'h0B, 16'h0004});
		write_reg(1'b1, SEQ_MEM_MODE, 8'h08);
		check_filtered("planar clear", {SEGMENT, 16'h0004});

		for (int i = 0; i < READS_PER_MODE; i++)
		begin
			randomize_regs();
			rmode = 1'b1;
			load_regs();
			do_access("read mode 1", 1'b0);
		end

		for (int m = 0; m < 4; m++)
			for (int i = 0; i < WRITES_PER_MODE; i++)
			begin
				randomize_regs();
				wmode = m[1:0];
				load_regs();
				do_access($sformatf("write mode %0d", m), 1'b1);
			end

		wait_ready();
		if (dut.u_checker.error_count == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
		begin
			$display("handshake assertions in the checker failed");
			$display("test failed");
			$fatal(1, "checker failure");
		end
	end

endmodule

// File: flist.f
source/vga_gc_pkg.sv
source/vga_io_regs.sv
source/vga_data_path.sv
source/vga_mem_sequencer.sv
source/vga_gc_top.sv
dv/vga_gc_checker.sv
dv/vga_gc_tb.sv

// File: source/vga_data_path.sv
`timescale 1ns/1ps

module vga_data_path
	import vga_gc_pkg::*;
(
	input gc_regs_t gc_regs,
	input cpu_req_t req,
	input plane_word_t latch,
	input plane_word_t mem_word,
	output plane_word_t store_word,
	output logic [7:0] read_byte
);

	// One bit per plane spread over that plane's byte
	function automatic plane_word_t expand_planes(input logic [3:0] bits);
		expand_planes = {{8{bits[3]}}, {8{bits[2]}}, {8{bits[1]}}, {8{bits[0]}}};
	endfunction

	logic [15:0] data_twice;
	logic [7:0] rotated;
	plane_word_t byte_word;
	plane_word_t sr_word;
	plane_word_t sr_enable;
	plane_word_t bit_mask_word;
	plane_word_t operand;
	plane_word_t op_mask;
	plane_word_t logic_result;
	plane_word_t plane_mask;
	plane_word_t cmp_word;
	logic [7:0] cmp_byte;

	//////////////////////////////////////////////////
	// Write side
	//////////////////////////////////////////////////

	assign data_twice = {req.data, req.data};
	assign rotated = data_twice[gc_regs.rotate +: 8];

	assign byte_word = {4{rotated}};
	assign sr_word = expand_planes(gc_regs.set_reset);
	assign sr_enable = expand_planes(gc_regs.enable_set_reset);
	assign bit_mask_word = {4{gc_regs.bit_mask}};
	assign plane_mask = expand_planes(gc_regs.plane_enable);

	always_comb
	begin
		op_mask = bit_mask_word;
		case (gc_regs.write_mode)
			2'd0: operand = (sr_word & sr_enable) | (byte_word & ~sr_enable);
			2'd1: operand = latch;
			2'd2: operand = expand_planes(req.data[3:0]);
			default:
			begin
				operand = sr_word;
				op_mask = byte_word & bit_mask_word;
			end
		endcase
	end

	always_comb
	begin
		case (gc_regs.logic_op)
			2'd0: logic_result = (operand & op_mask) | (latch & ~op_mask);
			2'd1: logic_result = (operand | ~op_mask) & latch;
			2'd2: logic_result = (operand & op_mask) | latch;
			default: logic_result = (operand & op_mask) ^ latch;
		endcase
		// Mode 1 is a plain latch copy whatever the logic operation
		if (gc_regs.write_mode == 2'd1)
			logic_result = latch;
	end

	assign store_word = (logic_result & plane_mask) | (mem_word & ~plane_mask);

	//////////////////////////////////////////////////
	// Read side
	//////////////////////////////////////////////////

	// A pixel matches when every cared-for plane equals the compare colour
	assign cmp_word = (mem_word & expand_planes(gc_regs.color_dont_care)) ^
		expand_planes(gc_regs.color_compare & gc_regs.color_dont_care);
	assign cmp_byte = ~(cmp_word[31:24] | cmp_word[23:16] | cmp_word[15:8] | cmp_word[7:0]);

	assign read_byte = gc_regs.read_mode ? cmp_byte :
		mem_word[gc_regs.read_plane * 8 +: 8];

endmodule

// File: source/vga_gc_pkg.sv
package vga_gc_pkg;

	//////////////////////////////////////////////////
	// Basic words
	//////////////////////////////////////////////////

	// Four planes of one byte each, plane 0 in the low byte
	typedef logic [31:0] plane_word_t;

	typedef logic [11:0] io_port_t;

	// I/O ports of the sequencer and graphics controller
	localparam io_port_t PORT_SEQ_INDEX = 12'h3C4;
	localparam io_port_t PORT_SEQ_DATA = 12'h3C5;
	localparam io_port_t PORT_GC_INDEX = 12'h3CE;
	localparam io_port_t PORT_GC_DATA = 12'h3CF;

	// Sequencer register indices
	localparam logic [4:0] SEQ_MAP_MASK = 5'h02;
	localparam logic [4:0] SEQ_MEM_MODE = 5'h04;

	// Graphics controller register indices
	localparam logic [4:0] GC_SET_RESET = 5'h00;
	localparam logic [4:0] GC_ENABLE_SR = 5'h01;
	localparam logic [4:0] GC_COLOR_CMP = 5'h02;
	localparam logic [4:0] GC_ROTATE = 5'h03;
	localparam logic [4:0] GC_READ_MAP = 5'h04;
	localparam logic [4:0] GC_MODE = 5'h05;
	localparam logic [4:0] GC_DONT_CARE = 5'h07;
	localparam logic [4:0] GC_BIT_MASK = 5'h08;

	//////////////////////////////////////////////////
	// Control and request records
	//////////////////////////////////////////////////

	typedef struct packed {
		logic planar;
		logic [3:0] plane_enable;
		logic [3:0] set_reset;
		logic [3:0] enable_set_reset;
		logic [3:0] color_compare;
		logic [2:0] rotate;
		logic [1:0] logic_op;
		logic [1:0] read_plane;
		logic [1:0] write_mode;
		logic read_mode;
		logic [3:0] color_dont_care;
		logic [7:0] bit_mask;
	} gc_regs_t;

	// Processor access as captured at acceptance
	typedef struct packed {
		logic [15:0] offset;
		logic [7:0] data;
		logic is_write;
	} cpu_req_t;

	typedef enum logic [1:0] {
		idle,
		read,
		write_read,
		write_store
	} gc_state_t;

endpackage

// File: source/vga_gc_top.sv
`timescale 1ns/1ps

module vga_gc_top
	import vga_gc_pkg::*;
#(
	parameter logic [7:0] VRAM_SEGMENT = 8'h0A
)
(
	input logic clk,
	input logic arst_n,
	input logic [23:0] a,
	input logic [7:0] din,
	output logic [7:0] dout,
	input logic mrd_req,
	output logic mrd_ack,
	input logic mwr_req,
	output logic mwr_ack,
	input io_port_t port,
	input logic [15:0] iodin,
	output logic [15:0] iodout,
	input logic iowr_req,
	output logic iowr_ack,
	input logic iord_req,
	output logic iord_ack,
	output logic [23:0] gpu_addr,
	output plane_word_t gpu_dout,
	input plane_word_t gpu_din,
	input logic gpu_rd_ack,
	output logic gpu_rd_req,
	input logic gpu_wr_ack,
	output logic gpu_wr_req,
	output logic ready
);

	gc_regs_t gc_regs;
	cpu_req_t req;
	plane_word_t latch;
	plane_word_t store_word;
	logic [7:0] read_byte;
	logic busy;
	logic mrd_pending;
	logic mwr_pending;
	logic iowr_pending;
	logic iord_pending;

	assign mrd_pending = mrd_req != mrd_ack;
	assign mwr_pending = mwr_req != mwr_ack;
	assign iowr_pending = iowr_req != iowr_ack;
	assign iord_pending = iord_req != iord_ack;

	assign ready = !busy && !iowr_pending && !iord_pending;

	// Processor and I/O requests finish one cycle after they arrive
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mrd_ack <= 1'b0;
			mwr_ack <= 1'b0;
			iowr_ack <= 1'b0;
			iord_ack <= 1'b0;
		end
		else
		begin
			mrd_ack <= mrd_req;
			mwr_ack <= mwr_req;
			iowr_ack <= iowr_req;
			iord_ack <= iord_req;
		end
	end

	vga_io_regs u_io_regs (
		.clk(clk),
		.arst_n(arst_n),
		.port(port),
		.iodin(iodin),
		.iowr_pending(iowr_pending),
		.iodout(iodout),
		.gc_regs(gc_regs)
	);

	vga_data_path u_data_path (
		.gc_regs(gc_regs),
		.req(req),
		.latch(latch),
		.mem_word(gpu_din),
		.store_word(store_word),
		.read_byte(read_byte)
	);

	vga_mem_sequencer #(
		.VRAM_SEGMENT(VRAM_SEGMENT)
	) u_mem_sequencer (
		.clk(clk),
		.arst_n(arst_n),
		.a(a),
		.din(din),
		.mrd_pending(mrd_pending),
		.mwr_pending(mwr_pending),
		.gc_regs(gc_regs),
		.store_word(store_word),
		.read_byte(read_byte),
		.gpu_din(gpu_din),
		.gpu_rd_ack(gpu_rd_ack),
		.gpu_wr_ack(gpu_wr_ack),
		.req(req),
		.latch(latch),
		.gpu_addr(gpu_addr),
		.gpu_dout(gpu_dout),
		.gpu_rd_req(gpu_rd_req),
		.gpu_wr_req(gpu_wr_req),
		.dout(dout),
		.busy(busy)
	);

endmodule

// File: source/vga_io_regs.sv
`timescale 1ns/1ps

module vga_io_regs
	import vga_gc_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input io_port_t port,
	input logic [15:0] iodin,
	input logic iowr_pending,
	output logic [15:0] iodout,
	output gc_regs_t gc_regs
);

	logic [4:0] seq_index;
	logic [4:0] gc_index;
	logic [7:0] seq_data;
	logic [7:0] gc_data;

	//////////////////////////////////////////////////
	// Register writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			seq_index <= '0;
			gc_index <= '0;
			gc_regs <= '0;
		end
		else if (iowr_pending)
		begin
			case (port)
				PORT_SEQ_INDEX:
					seq_index <= iodin[4:0];
				PORT_SEQ_DATA:
				begin
					if (seq_index == SEQ_MAP_MASK)
						gc_regs.plane_enable <= iodin[3:0];
					// Chain 4 bit clear selects planar addressing
					if (seq_index == SEQ_MEM_MODE)
						gc_regs.planar <= ~iodin[3];
				end
				PORT_GC_INDEX:
					gc_index <= iodin[4:0];
				PORT_GC_DATA:
				begin
					case (gc_index)
						GC_SET_RESET: gc_regs.set_reset <= iodin[3:0];
						GC_ENABLE_SR: gc_regs.enable_set_reset <= iodin[3:0];
						GC_COLOR_CMP: gc_regs.color_compare <= iodin[3:0];
						GC_ROTATE:
						begin
							gc_regs.rotate <= iodin[2:0];
							gc_regs.logic_op <= iodin[4:3];
						end
						GC_READ_MAP: gc_regs.read_plane <= iodin[1:0];
						GC_MODE:
						begin
							gc_regs.write_mode <= iodin[1:0];
							gc_regs.read_mode <= iodin[3];
						end
						GC_DONT_CARE: gc_regs.color_dont_care <= iodin[3:0];
						GC_BIT_MASK: gc_regs.bit_mask <= iodin[7:0];
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Read-back
	//////////////////////////////////////////////////

	always_comb
	begin
		case (seq_index)
			SEQ_MAP_MASK: seq_data = {4'h0, gc_regs.plane_enable};
			SEQ_MEM_MODE: seq_data = {4'h0, ~gc_regs.planar, 3'b000};
			default: seq_data = 8'h00;
		endcase
	end

	always_comb
	begin
		case (gc_index)
			GC_SET_RESET: gc_data = {4'h0, gc_regs.set_reset};
			GC_ENABLE_SR: gc_data = {4'h0, gc_regs.enable_set_reset};
			GC_COLOR_CMP: gc_data = {4'h0, gc_regs.color_compare};
			GC_ROTATE: gc_data = {3'b000, gc_regs.logic_op, gc_regs.rotate};
			GC_READ_MAP: gc_data = {6'b000000, gc_regs.read_plane};
			GC_MODE: gc_data = {4'h0, gc_regs.read_mode, 1'b0, gc_regs.write_mode};
			GC_DONT_CARE: gc_data = {4'h0, gc_regs.color_dont_care};
			GC_BIT_MASK: gc_data = gc_regs.bit_mask;
			default: gc_data = 8'h00;
		endcase
	end

	// Other ports keep the last value
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			iodout <= '0;
		else
		begin
			case (port)
				PORT_SEQ_INDEX: iodout <= {11'h000, seq_index};
				PORT_SEQ_DATA: iodout <= {8'h00, seq_data};
				PORT_GC_INDEX: iodout <= {11'h000, gc_index};
				PORT_GC_DATA: iodout <= {8'h00, gc_data};
				default: ;
			endcase
		end
	end

endmodule

// File: source/vga_mem_sequencer.sv
`timescale 1ns/1ps

module vga_mem_sequencer
	import vga_gc_pkg::*;
#(
	parameter logic [7:0] VRAM_SEGMENT = 8'h0A
)
(
	input logic clk,
	input logic arst_n,
	input logic [23:0] a,
	input logic [7:0] din,
	input logic mrd_pending,
	input logic mwr_pending,
	input gc_regs_t gc_regs,
	input plane_word_t store_word,
	input logic [7:0] read_byte,
	input plane_word_t gpu_din,
	input logic gpu_rd_ack,
	input logic gpu_wr_ack,
	output cpu_req_t req,
	output plane_word_t latch,
	output logic [23:0] gpu_addr,
	output plane_word_t gpu_dout,
	output logic gpu_rd_req,
	output logic gpu_wr_req,
	output logic [7:0] dout,
	output logic busy
);

	localparam logic [23:0] VRAM_BASE = 24'hA0000;

	gc_state_t state;
	logic seg_hit;
	logic accept;
	logic rd_done;
	logic wr_done;
	logic mem_word_valid;

	assign seg_hit = (a[23:16] == VRAM_SEGMENT) && gc_regs.planar;
	assign accept = (state == idle) && seg_hit && (mrd_pending || mwr_pending);

	assign rd_done = gpu_rd_ack == gpu_rd_req;
	assign wr_done = gpu_wr_ack == gpu_wr_req;

	// Memory word on gpu_din is good on this edge
	assign mem_word_valid = ((state == read) || (state == write_read)) && rd_done;

	assign busy = state != idle;

	// Each plane byte sits in its own lane of a 32-bit word
	assign gpu_addr = VRAM_BASE + {6'b000000, req.offset, 2'b00};

	//////////////////////////////////////////////////
	// FSM and memory toggles
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= idle;
			gpu_rd_req <= 1'b0;
			gpu_wr_req <= 1'b0;
		end
		else
		begin
			case (state)
				idle:
					if (accept)
					begin
						gpu_rd_req <= ~gpu_rd_req;
						// Reads win over writes
						state <= mrd_pending ? read : write_read;
					end
				read:
					if (rd_done)
						state <= idle;
				write_read:
					if (rd_done)
					begin
						gpu_wr_req <= ~gpu_wr_req;
						state <= write_store;
					end
				write_store:
					if (wr_done)
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Request capture, latch and data
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req.offset <= a[15:0];
			req.data <= din;
			req.is_write <= ~mrd_pending;
		end
		if (mem_word_valid)
			latch <= gpu_din;
		// Store word still sees the old latch here
		if (mem_word_valid && req.is_write)
			gpu_dout <= store_word;
		if (mem_word_valid && !req.is_write)
			dout <= read_byte;
	end

endmodule
